//--- logic/ifu_pkg.sv
package ifu_pkg;

    // bus and datapath widths
    typedef logic [31:0] addr_t;      // byte address, fetch path and AXI
    typedef logic [31:0] instr_t;     // one RV32 instruction word
    typedef logic [63:0] axi_data_t;  // one read beat, two instruction lanes
    typedef logic [1:0]  axi_resp_t;  // 2'b00 is OKAY, anything else faults

    // first fetch address after reset
    localparam addr_t RESET_PC = 32'h8000_0000;

    // sequential step, no compressed instructions
    localparam int INSTR_BYTES = 4;

    // fetch buffer entries between bridge and decode
    localparam int FETCH_DEPTH = 2;

    // arprot for fetch
    // bit 0 unprivileged, bit 1 secure, bit 2 instruction access
    localparam logic [2:0] AXI_PROT_FETCH = 3'b100;

    // read bridge states
    // gray-style walk, only one bit changes per transition
    typedef enum logic [1:0] {
        RD_IDLE    = 2'b00,  // waiting for a fetch request
        RD_AR_WAIT = 2'b01,  // arvalid up, waiting for arready
        RD_R_WAIT  = 2'b11,  // rready up, waiting for rvalid
        RD_DONE    = 2'b10   // result registered, rsp pulse out
    } rd_state_e;

endpackage

//--- logic/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic           clock,
    input  logic           reset,             // async, active low
    input  logic           redirect_valid_i,  // one-cycle pulse
    input  ifu_pkg::addr_t redirect_pc_i,     // new stream start
    input  logic           req_ready_i,       // bridge can take a request
    output logic           req_valid_o,       // request offered
    output ifu_pkg::addr_t req_pc_o           // address of the offered request
);
    import ifu_pkg::*;

    addr_t pc_q;      // program counter, next address to fetch
    addr_t pc_inc;    // sequential successor
    logic  valid_q;   // out of reset, always offering
    logic  req_fire;  // request handed to the bridge this cycle

    assign req_fire = req_valid_o && req_ready_i;
    assign pc_inc   = pc_q + addr_t'(INSTR_BYTES);

    // request valid comes up one cycle after reset release
    // and then stays up, the bridge does the throttling
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    // pc update
    // redirect first, then increment on an accepted request
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;     // new stream, overrides the step
        end else if (req_fire) begin
            pc_q <= pc_inc;            // next word in sequence
        end
    end

    assign req_valid_o = valid_q;
    assign req_pc_o    = pc_q;         // held while not accepted

    // address must not move under a pending request
    // unless decode redirected the stream
    property p_req_pc_hold;
        @(posedge clock) disable iff (!reset)
        (req_valid_o && !req_ready_i && !redirect_valid_i) |=> $stable(req_pc_o);
    endproperty

    a_req_pc_hold : assert property (p_req_pc_hold)
        else $error("fetch_pc_gen: req_pc_o changed while request pending");

endmodule

//--- logic/axi_rd_master.sv
`timescale 1ns/1ps

module axi_rd_master (
    input  logic                clock,
    input  logic                reset,        // async, active low
    // fetch request from the pc generator
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  ifu_pkg::addr_t      req_pc_i,
    // buffer side
    input  logic                has_space_i,  // room for one more result
    input  logic                flush_i,      // redirect, drop in-flight read
    output logic                rsp_valid_o,  // one-cycle pulse
    output ifu_pkg::instr_t     rsp_instr_o,
    output ifu_pkg::addr_t      rsp_pc_o,
    output logic                rsp_fault_o,
    // AXI4-Lite read address channel
    input  logic                m_arready_i,
    output logic                m_arvalid_o,
    output ifu_pkg::addr_t      m_araddr_o,
    output logic [2:0]          m_arprot_o,
    // AXI4-Lite read data channel
    input  logic                m_rvalid_i,
    output logic                m_rready_o,
    input  ifu_pkg::axi_data_t  m_rdata_i,
    input  ifu_pkg::axi_resp_t  m_rresp_i
);
    import ifu_pkg::*;

    rd_state_e state_q, state_d;
    logic      ar_valid, r_ready;   // decoded from state
    logic      req_fire;            // request taken in idle
    logic      r_fire;              // R handshake
    logic      drop_q;              // in-flight read belongs to a flushed stream
    addr_t     addr_q;              // captured fetch address
    instr_t    lane;                // word picked out of the beat

    assign req_fire = req_valid_i && req_ready_o;
    assign r_fire   = m_rvalid_i && r_ready;

    // take a request only when idle, with room reserved and no redirect
    // in the same cycle, otherwise the old address would slip through
    assign req_ready_o = (state_q == RD_IDLE) && has_space_i && !flush_i;

    // state register
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= RD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (req_fire) state_d = RD_AR_WAIT;
            end
            RD_AR_WAIT: begin
                if (m_arready_i) state_d = RD_R_WAIT;   // address accepted
            end
            RD_R_WAIT: begin
                if (m_rvalid_i) state_d = RD_DONE;      // beat arrives
            end
            RD_DONE: begin
                state_d = RD_IDLE;                      // one cycle for the rsp pulse
            end
            default: begin
                state_d = RD_IDLE;
            end
        endcase
    end

    // channel handshakes per state
    always_comb begin
        case (state_q)
            RD_AR_WAIT: begin
                ar_valid = 1'b1;
                r_ready  = 1'b0;
            end
            RD_R_WAIT: begin
                ar_valid = 1'b0;
                r_ready  = 1'b1;
            end
            default: begin               // idle and done are quiet
                ar_valid = 1'b0;
                r_ready  = 1'b0;
            end
        endcase
    end

    // address capture at request time, AR is driven from here
    always_ff @(posedge clock) begin
        if (req_fire) begin
            addr_q <= req_pc_i;
        end
    end

    // drop marker
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            drop_q <= 1'b0;
        end else if (req_fire) begin
            drop_q <= 1'b0;              // fresh read
        end else if (flush_i && (state_q == RD_AR_WAIT || state_q == RD_R_WAIT)) begin
            drop_q <= 1'b1;              // finish on the bus, discard data
        end
    end

    // bit 2 selects upper or lower word of the 64-bit beat
    assign lane = addr_q[2] ? m_rdata_i[63:32] : m_rdata_i[31:0];

    // result registers
    always_ff @(posedge clock) begin
        if (r_fire) begin
            rsp_instr_o <= lane;
            rsp_fault_o <= (m_rresp_i != 2'b00);   // slverr or decerr
        end
    end

    // response pulse, flush in the R cycle itself also kills it
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= r_fire && !drop_q && !flush_i;
        end
    end

    assign rsp_pc_o    = addr_q;          // still valid in RD_DONE
    assign m_arvalid_o = ar_valid;
    assign m_araddr_o  = addr_q;          // stable for the whole AR wait
    assign m_arprot_o  = AXI_PROT_FETCH;
    assign m_rready_o  = r_ready;

    // once raised, arvalid and araddr hold until arready
    property p_ar_hold;
        @(posedge clock) disable iff (!reset)
        (m_arvalid_o && !m_arready_i) |=> (m_arvalid_o && $stable(m_araddr_o));
    endproperty

    a_ar_hold : assert property (p_ar_hold)
        else $error("axi_rd_master: AR dropped or changed before arready");

    // rready only while a read is waiting for its beat
    a_rready_state : assert property (
        @(posedge clock) disable iff (!reset)
        m_rready_o |-> (state_q == RD_R_WAIT))
        else $error("axi_rd_master: rready outside RD_R_WAIT");

endmodule

//--- logic/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer (
    input  logic            clock,
    input  logic            reset,          // async, active low
    input  logic            flush_i,        // redirect empties everything
    // write side, from the read bridge
    input  logic            wr_valid_i,
    input  ifu_pkg::instr_t wr_instr_i,
    input  ifu_pkg::addr_t  wr_pc_i,
    input  logic            wr_fault_i,
    output logic            has_space_o,    // fewer than FETCH_DEPTH held
    // decode side
    output logic            instr_valid_o,
    input  logic            instr_ready_i,
    output ifu_pkg::instr_t instr_o,
    output ifu_pkg::addr_t  instr_pc_o,
    output logic            instr_fault_o
);
    import ifu_pkg::*;

    typedef logic [$clog2(FETCH_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(FETCH_DEPTH+1)-1:0] cnt_t;

    instr_t mem_instr [FETCH_DEPTH];   // entry storage
    addr_t  mem_pc    [FETCH_DEPTH];
    logic   mem_fault [FETCH_DEPTH];

    ptr_t wr_ptr_q, rd_ptr_q;
    cnt_t count_q;
    logic push, pop;

    assign push = wr_valid_i && !flush_i;        // flushed data never lands
    assign pop  = instr_valid_o && instr_ready_i;

    // entry write
    always_ff @(posedge clock) begin
        if (push) begin
            mem_instr[wr_ptr_q] <= wr_instr_i;
            mem_pc[wr_ptr_q]    <= wr_pc_i;
            mem_fault[wr_ptr_q] <= wr_fault_i;
        end
    end

    // pointers and count, push and pop may share a cycle
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;                    // drop all held entries
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign has_space_o   = (count_q < cnt_t'(FETCH_DEPTH));
    assign instr_valid_o = (count_q != '0);
    assign instr_o       = mem_instr[rd_ptr_q];   // head entry
    assign instr_pc_o    = mem_pc[rd_ptr_q];
    assign instr_fault_o = mem_fault[rd_ptr_q];

    // bridge reserves a slot before each read, so a write never finds it full
    a_no_overflow : assert property (
        @(posedge clock) disable iff (!reset)
        wr_valid_i |-> (count_q < cnt_t'(FETCH_DEPTH)))
        else $error("fetch_buffer: write while full");

endmodule

//--- logic/ifu_top.sv
`timescale 1ns/1ps

module ifu_top (
    input  logic                clock,
    input  logic                reset,             // async, active low
    // redirect from execute
    input  logic                redirect_valid_i,
    input  ifu_pkg::addr_t      redirect_pc_i,
    // decode port
    output logic                instr_valid_o,
    input  logic                instr_ready_i,
    output ifu_pkg::instr_t     instr_o,
    output ifu_pkg::addr_t      instr_pc_o,
    output logic                instr_fault_o,
    // AXI4-Lite read master
    input  logic                m_arready_i,
    output logic                m_arvalid_o,
    output ifu_pkg::addr_t      m_araddr_o,
    output logic [2:0]          m_arprot_o,
    input  logic                m_rvalid_i,
    output logic                m_rready_o,
    input  ifu_pkg::axi_data_t  m_rdata_i,
    input  ifu_pkg::axi_resp_t  m_rresp_i
);
    import ifu_pkg::*;

    logic   req_valid, req_ready;  // generator to bridge
    addr_t  req_pc;
    logic   rsp_valid, rsp_fault;  // bridge to buffer
    instr_t rsp_instr;
    addr_t  rsp_pc;
    logic   has_space;             // buffer to bridge

    fetch_pc_gen fetch_pc_gen_i (
        .clock            (clock),
        .reset            (reset),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .req_ready_i      (req_ready),
        .req_valid_o      (req_valid),
        .req_pc_o         (req_pc)
    );

    axi_rd_master axi_rd_master_i (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_pc_i    (req_pc),
        .has_space_i (has_space),
        .flush_i     (redirect_valid_i),   // in-flight read gets dropped
        .rsp_valid_o (rsp_valid),
        .rsp_instr_o (rsp_instr),
        .rsp_pc_o    (rsp_pc),
        .rsp_fault_o (rsp_fault),
        .m_arready_i (m_arready_i),
        .m_arvalid_o (m_arvalid_o),
        .m_araddr_o  (m_araddr_o),
        .m_arprot_o  (m_arprot_o),
        .m_rvalid_i  (m_rvalid_i),
        .m_rready_o  (m_rready_o),
        .m_rdata_i   (m_rdata_i),
        .m_rresp_i   (m_rresp_i)
    );

    fetch_buffer fetch_buffer_i (
        .clock         (clock),
        .reset         (reset),
        .flush_i       (redirect_valid_i),  // empties held entries
        .wr_valid_i    (rsp_valid),
        .wr_instr_i    (rsp_instr),
        .wr_pc_i       (rsp_pc),
        .wr_fault_i    (rsp_fault),
        .has_space_o   (has_space),
        .instr_valid_o (instr_valid_o),
        .instr_ready_i (instr_ready_i),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_fault_o (instr_fault_o)
    );

endmodule

//--- sim/tb_ifu_top.sv
`timescale 1ns/1ps

module tb_ifu_top;
    import ifu_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam logic [31:0] SEED        = 32'h7e20f971;
    localparam addr_t       ERR_LO      = 32'h8000_4020;  // slverr window, eight words
    localparam addr_t       ERR_HI      = 32'h8000_403f;
    // about 60 instructions at up to 12 cycles each plus 80 flicker cycles
    // and a stall of at most 103 cycles stays below 1000 cycles
    localparam int          WATCHDOG_NS = 10_000 * CLK_PERIOD;

    logic       clock, reset;
    logic       redirect_valid;
    addr_t      redirect_pc;
    logic       instr_valid, instr_ready, instr_fault;
    instr_t     instr;
    addr_t      instr_pc;
    logic       arvalid, arready, rvalid, rready;
    addr_t      araddr;
    logic [2:0] arprot;
    axi_data_t  rdata;
    axi_resp_t  rresp;

    int          errors      = 0;
    int          pop_count   = 0;     // instructions taken by decode
    int          fault_count = 0;
    int          ar_issues   = 0;     // new AR requests seen
    int          ar_hs       = 0;
    int          r_hs        = 0;
    int          outstanding = 0;     // AR handshakes not yet answered
    int          held        = 0;     // model of buffer occupancy
    addr_t       exp_pc      = RESET_PC;  // next address decode should see
    addr_t       exp_ar      = RESET_PC;  // next address on AR
    addr_t       ar_prev_addr;
    logic        ar_wait     = 1'b0;  // AR up and not yet accepted
    logic        rd_live     = 1'b0;  // read in flight is not flushed
    logic        land_next   = 1'b0;  // beat lands in the buffer next edge
    logic [1:0]  lane_seen   = 2'b00;
    logic [31:0] slave_rng, stim_rng;

    ifu_top ifu_top_i (
        .clock            (clock),
        .reset            (reset),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .instr_valid_o    (instr_valid),
        .instr_ready_i    (instr_ready),
        .instr_o          (instr),
        .instr_pc_o       (instr_pc),
        .instr_fault_o    (instr_fault),
        .m_arready_i      (arready),
        .m_arvalid_o      (arvalid),
        .m_araddr_o       (araddr),
        .m_arprot_o       (arprot),
        .m_rvalid_i       (rvalid),
        .m_rready_o       (rready),
        .m_rdata_i        (rdata),
        .m_rresp_i        (rresp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
    endfunction

    // memory contents, every bit of the address matters
    function automatic instr_t word_at(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h1357_9bdf;
    endfunction

    function automatic axi_data_t beat_at(input addr_t a);
        addr_t base;
        base = {a[31:3], 3'b000};
        return {word_at(base | 32'h4), word_at(base)};   // upper lane is base+4
    endfunction

    function automatic logic in_err(input addr_t a);
        return (a >= ERR_LO) && (a <= ERR_HI);
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;                                  // drive phase
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("errors: %0d", errors);
        $display("FAIL: see errors above");
        $finish;
    end

    // AXI4-Lite read slave, random latency on AR and R
    initial begin : axi_slave
        addr_t ar_addr;
        slave_rng = SEED;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rresp     = '0;
        forever begin
            next_cycle();
            if (arvalid) begin
                slave_rng = lcg_next(slave_rng);
                repeat (slave_rng[17:16]) next_cycle();   // 0..3 cycles
                arready = 1'b1;
                ar_addr = araddr;
                next_cycle();                              // AR handshake
                arready   = 1'b0;
                slave_rng = lcg_next(slave_rng);
                repeat (slave_rng[17:16]) next_cycle();
                rvalid = 1'b1;
                rdata  = beat_at(ar_addr);
                rresp  = in_err(ar_addr) ? 2'b10 : 2'b00;  // slverr in window
                while (!rready) next_cycle();
                next_cycle();                              // R handshake
                rvalid = 1'b0;
                rdata  = '0;
                rresp  = '0;
            end
        end
    end

    // monitor and scoreboard, negedge sees everything settled
    always @(negedge clock) begin : monitor
        axi_data_t beat;
        if (reset) begin
            check("rready while a read is outstanding", rready, outstanding != 0);
            if (ar_wait) begin
                check("arvalid held until arready", arvalid, 1'b1);
                check("araddr stable until arready", araddr, ar_prev_addr);
            end else if (arvalid) begin
                check("araddr of new read", araddr, exp_ar);
                check("reads outstanding at AR issue", outstanding, 0);
                check("AR issued with buffer full", held < 2, 1'b1);
                exp_ar = exp_ar + 32'd4;
                ar_issues++;
                rd_live = 1'b1;
            end
            if (arvalid) check("arprot", arprot, AXI_PROT_FETCH);
            if (arvalid && arready) begin
                outstanding++;
                ar_hs++;
            end
            ar_wait      = arvalid && !arready;
            ar_prev_addr = araddr;
            if (land_next && !redirect_valid) held++;      // push from last beat
            land_next = 1'b0;
            if (rvalid && rready) begin
                outstanding--;
                r_hs++;
                land_next = rd_live && !redirect_valid;
                rd_live   = 1'b0;
            end
            if (instr_valid && instr_ready) begin
                beat = beat_at(instr_pc);
                check("instruction address", instr_pc, exp_pc);
                check("instruction word", instr, instr_pc[2] ? beat[63:32] : beat[31:0]);
                check("fault flag", instr_fault, in_err(instr_pc));
                lane_seen[instr_pc[2]] = 1'b1;
                if (instr_fault) fault_count++;
                pop_count++;
                held--;
                exp_pc = exp_pc + 32'd4;
            end
            if (redirect_valid) begin                      // old stream gone
                exp_pc  = redirect_pc;
                exp_ar  = redirect_pc;
                held    = 0;
                rd_live = 1'b0;
            end
        end
    end

    task automatic wait_pops(input int n);
        int target;
        int cycles;
        target = pop_count + n;
        cycles = 0;
        while (pop_count < target && cycles < 400) begin
            next_cycle();
            cycles++;
        end
        if (pop_count < target) begin
            errors++;
            $display("timed out after %0d cycles waiting for %0d instructions", cycles, n);
        end
    endtask

    task automatic pulse_redirect(input addr_t target);
        redirect_pc    = target;
        redirect_valid = 1'b1;
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    task automatic run_sequential();
        instr_ready = 1'b1;
        wait_pops(12);
        check("both lanes delivered", lane_seen, 2'b11);
    endtask

    task automatic run_axi_rules();
        repeat (80) begin                    // decode ready flickers
            stim_rng    = lcg_next(stim_rng);
            instr_ready = stim_rng[16];
            next_cycle();
        end
        instr_ready = 1'b1;
        wait_pops(4);
        check("AR minus R handshakes", (ar_hs - r_hs) <= 1, 1'b1);
    endtask

    task automatic run_back_pressure();
        int stall;
        int issues_before;
        stim_rng      = lcg_next(stim_rng);
        stall         = 40 + int'(stim_rng[21:16]);
        issues_before = ar_issues;
        instr_ready   = 1'b0;
        repeat (stall) next_cycle();
        check("ARs issued during stall", (ar_issues - issues_before) <= 2, 1'b1);
        check("entries held after stall", held, 2);
        instr_ready = 1'b1;
        wait_pops(10);
    endtask

    task automatic run_redirects();
        while (arvalid || rready) next_cycle();     // between reads
        pulse_redirect(32'h8000_1000);
        wait_pops(6);
        while (!arvalid) next_cycle();              // AR wait
        pulse_redirect(32'h8000_2004);
        wait_pops(6);
        while (!rready) next_cycle();               // R wait
        pulse_redirect(32'h8000_300c);
        wait_pops(6);
    endtask

    task automatic run_fault();
        int faults_before;
        pulse_redirect(ERR_LO - 32'd16);            // four words before the window
        faults_before = fault_count;
        wait_pops(16);
        check("faulting instructions", fault_count - faults_before, 8);
    endtask

    initial begin : main
        reset          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        instr_ready    = 1'b0;
        stim_rng       = lcg_next(lcg_next(SEED));  // two steps ahead of the slave
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b1;
        run_sequential();
        run_axi_rules();
        run_back_pressure();
        run_redirects();
        run_fault();
        $display("errors: %0d, instructions checked: %0d", errors, pop_count);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/ifu_pkg.sv
logic/fetch_pc_gen.sv
logic/axi_rd_master.sv
logic/fetch_buffer.sv
logic/ifu_top.sv
sim/tb_ifu_top.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_ifu_top
FILELIST  := compile.f
BUILD_DIR := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
